//--- rx_serdes_pkg.sv
//**************************************************
// RX serdes shared definitions
// Word framing, input delay depth, post-reset settle
// count and the bit and word structs between stages
//**************************************************
package rx_serdes_pkg;

    //**************************************************
    // Word framing
    //**************************************************
    localparam int unsigned word_width = 3;               // Bits per word, at least 2
    localparam int unsigned cnt_width  = $clog2(word_width); // Bit counter width
    localparam logic [cnt_width-1:0] cnt_last =
        cnt_width'(word_width - 1);                        // Count of last bit in a word

    //**************************************************
    // Input conditioning
    //**************************************************
    localparam int unsigned dly_taps = 2;                  // Fixed delay stages

    //**************************************************
    // Post-reset settle
    //**************************************************
    localparam int unsigned settle_width = 8;              // Settle counter width
    localparam logic [settle_width-1:0] settle_max =
        settle_width'(255);                                // All ones, ready from here

    // Conditioned serial bit, one per clock
    typedef struct packed {
        logic bit_val;                                     // Serial data bit
        logic bit_en;                                      // Active high enable
    } rx_bit_t;

    // Deserialized word with its strobe
    typedef struct packed {
        logic [word_width-1:0] data;                       // MSB is first bit received
        logic                  valid;                      // One cycle per word
    } rx_word_t;

endpackage

//--- rx_input_stage.sv
//**************************************************
// RX input stage
// Two-flop synchronizer on the data and enable pins
// followed by a fixed register delay chain
//**************************************************
`timescale 1ns/10ps

module rx_input_stage (
    input  logic                   fabric_clk_div,
    input  logic                   reset_buf_n,
    input  logic                   data_i,
    input  logic                   enable_n,
    output rx_serdes_pkg::rx_bit_t bit_out
);

    logic                   data_meta_q;                   // First flop, data pin
    logic                   en_meta_n_q;                   // First flop, raw active low enable
    rx_serdes_pkg::rx_bit_t sync_q;                        // Second flop, enable now active high
    rx_serdes_pkg::rx_bit_t dly_q [rx_serdes_pkg::dly_taps]; // Fixed delay chain

    //**************************************************
    // Synchronizer
    //**************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_meta_q <= 1'b0;
            en_meta_n_q <= 1'b1;                           // Pin idle level, disabled
            sync_q      <= '0;
        end else begin
            data_meta_q    <= data_i;
            en_meta_n_q    <= enable_n;
            sync_q.bit_val <= data_meta_q;
            sync_q.bit_en  <= ~en_meta_n_q;                // Flip to active high
        end
    end

    //**************************************************
    // Fixed delay chain
    //**************************************************
    // Data and enable travel together so they stay aligned
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            for (int i = 0; i < rx_serdes_pkg::dly_taps; i++) begin
                dly_q[i] <= '0;                            // Cleared and disabled
            end
        end else begin
            dly_q[0] <= sync_q;                            // Head of chain
            for (int i = 1; i < rx_serdes_pkg::dly_taps; i++) begin
                dly_q[i] <= dly_q[i-1];                    // One clock per tap
            end
        end
    end

    assign bit_out = dly_q[rx_serdes_pkg::dly_taps-1];     // Tail of chain

endmodule

//--- rx_deserializer.sv
//**************************************************
// RX deserializer
// Shifts enabled bits in MSB first and strobes each
// completed word for one clock
//**************************************************
`timescale 1ns/10ps

module rx_deserializer (
    input  logic                    fabric_clk_div,
    input  logic                    reset_buf_n,
    input  rx_serdes_pkg::rx_bit_t  bit_in,
    output rx_serdes_pkg::rx_word_t word_out
);

    logic [rx_serdes_pkg::word_width-2:0] shift_q;        // Bits of the word so far
    logic [rx_serdes_pkg::word_width-1:0] shift_d;        // Word including current bit
    logic [rx_serdes_pkg::cnt_width-1:0]  cnt_q;          // Bits taken in current word
    logic                                 last_bit;       // Current bit closes the word
    rx_serdes_pkg::rx_word_t              word_q;         // Registered word and strobe

    //**************************************************
    // Next shift value
    //**************************************************
    assign shift_d  = {shift_q, bit_in.bit_val};          // MSB first
    assign last_bit = bit_in.bit_en && (cnt_q == rx_serdes_pkg::cnt_last);

    //**************************************************
    // Shift register and bit counter
    //**************************************************
    // Disabled cycles hold everything, framing only
    // moves on enabled bits
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            shift_q <= '0;
            cnt_q   <= '0;                                // First enabled bit starts a word
        end else if (bit_in.bit_en) begin
            shift_q <= shift_d[rx_serdes_pkg::word_width-2:0];
            if (last_bit) begin
                cnt_q <= '0;                              // Wrap for next word
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    //**************************************************
    // Word output register
    //**************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            word_q <= '0;
        end else begin
            word_q.valid <= last_bit;                     // Single clock strobe
            if (last_bit) begin
                word_q.data <= shift_d;                   // Completed word
            end
        end
    end

    assign word_out = word_q;

endmodule

//--- rx_word_capture.sv
//**************************************************
// RX word capture
// Waits a fixed settle time after reset, then holds
// the last valid word on the parallel output
//**************************************************
`timescale 1ns/10ps

module rx_word_capture (
    input  logic                                 fabric_clk_div,
    input  logic                                 reset_buf_n,
    input  rx_serdes_pkg::rx_word_t              word_in,
    output logic [rx_serdes_pkg::word_width-1:0] data_o,
    output logic                                 ready
);

    logic [rx_serdes_pkg::settle_width-1:0] settle_q;     // Clocks since reset release
    logic                                   settled;      // Counter at its limit

    //**************************************************
    // Settle counter
    //**************************************************
    // Stands in for the lock wait, saturates at the limit
    assign settled = (settle_q == rx_serdes_pkg::settle_max);

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            settle_q <= '0;
        end else if (!settled) begin
            settle_q <= settle_q + 1'b1;                  // One step per clock
        end
    end

    assign ready = settled;                               // Level, stays high until reset

    //**************************************************
    // Output word register
    //**************************************************
    // Words before ready are dropped, newer words
    // overwrite the held one
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o <= '0;
        end else if (word_in.valid && settled) begin
            data_o <= word_in.data;                       // Take strobed word
        end
    end

endmodule

//--- rx_serdes_top.sv
//**************************************************
// RX serdes top level
// Input conditioning, deserializer and word capture
// on the single fabric clock
//**************************************************
`timescale 1ns/10ps

module rx_serdes_top (
    input  logic                                 fabric_clk_div,
    input  logic                                 reset_buf_n,
    input  logic                                 data_i,      // Serial data pin
    input  logic                                 enable_n,    // Active low enable pin
    output logic [rx_serdes_pkg::word_width-1:0] data_o,      // Last captured word
    output logic                                 ready        // Settle time elapsed
);

    rx_serdes_pkg::rx_bit_t  rx_bit;                          // Conditioned bit stream
    rx_serdes_pkg::rx_word_t rx_word;                         // Word and its strobe

    //**************************************************
    // Input conditioning
    //**************************************************
    rx_input_stage input_stage (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .data_i         (data_i),
        .enable_n       (enable_n),
        .bit_out        (rx_bit)
    );

    //**************************************************
    // Deserializer
    //**************************************************
    rx_deserializer deserializer (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .bit_in         (rx_bit),
        .word_out       (rx_word)
    );

    //**************************************************
    // Word capture
    //**************************************************
    rx_word_capture word_capture (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .word_in        (rx_word),
        .data_o         (data_o),
        .ready          (ready)
    );

endmodule

//--- tb_rx_serdes_top.sv
//**************************************************
// RX serdes testbench
// LFSR serial stimulus, reference word model and a
// compare process on the parallel output
//**************************************************
`timescale 1ns/10ps

module tb_rx_serdes_top;

    localparam int ww = rx_serdes_pkg::word_width;        // Bits per word
    localparam int settle_edges = 255;                   // Edges until ready, all ones count

    logic          fabric_clk_div;
    logic          reset_buf_n;
    logic          data_i;
    logic          enable_n;
    logic [ww-1:0] data_o;
    logic          ready;

    logic [31:0]   lfsr_state;                           // Stimulus generator state
    int            edge_cnt;                             // Rising edges since start
    int            release_edge;                         // Edge count at reset release
    logic          capture_on;                           // Closed words are due on data_o
    logic          fed_bits [$];                         // Enabled bits since last reset
    logic [ww-1:0] exp_q [$];                            // Expected words in flight
    int            due_q [$];                            // Edge at which each word shows

    rx_serdes_top DUT (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .data_i         (data_i),
        .enable_n       (enable_n),
        .data_o         (data_o),
        .ready          (ready)
    );

    //**************************************************
    // Clock and edge count
    //**************************************************
    initial begin
        fabric_clk_div = 1'b0;
        forever #50 fabric_clk_div = ~fabric_clk_div;    // 100 ns period
    end

    always @(posedge fabric_clk_div) edge_cnt <= edge_cnt + 1;

    //**************************************************
    // Helpers
    //**************************************************
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois, right shift
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);              // One step per bit
        b = lfsr_state[0];
    endtask

    // Last complete word of the enabled bit list, MSB first
    function automatic logic [ww-1:0] ref_word();
        int            n;
        logic [ww-1:0] w;
        n = (fed_bits.size() / ww) * ww;
        w = '0;                                          // Output value after reset
        for (int i = n - ww; i < n && n > 0; i++) begin
            w = {w[ww-2:0], fed_bits[i]};
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // Called just after a falling edge
    task automatic drive_bit(input logic en);
        logic d;
        take_bit(d);
        data_i   = d;
        enable_n = ~en;                                  // Pin is active low
        if (en) begin
            fed_bits.push_back(d);
            if (capture_on && fed_bits.size() % ww == 0) begin // Word closes on this bit
                exp_q.push_back(ref_word());
                due_q.push_back(edge_cnt + 6);           // Sampling edge plus five
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge fabric_clk_div);
        reset_buf_n = 1'b0;
        data_i      = 1'b0;
        enable_n    = 1'b1;
        fed_bits.delete();                               // Framing restarts
        capture_on  = 1'b0;                              // Words dropped until ready
        repeat (4) begin
            @(negedge fabric_clk_div);
            check_value("data_o", 0, data_o);
            check_value("ready", 0, ready);
        end
        reset_buf_n  = 1'b1;
        release_edge = edge_cnt;
    endtask

    // Random bits until ready while data_o stays 0
    task automatic wait_settle();
        int t;
        t = 0;
        while (!ready) begin
            if (t > settle_edges + 20) fail_plain("Timed out waiting for ready");
            @(negedge fabric_clk_div);
            check_value("data_o", 0, data_o);
            if (edge_cnt - release_edge < settle_edges) check_value("ready", 0, ready);
            if (!ready) drive_bit(edge_cnt - release_edge < settle_edges / 2); // Early words
            t++;
        end
        check_value("ready_edge", settle_edges, edge_cnt - release_edge);
        capture_on = 1'b1;
    endtask

    task automatic drain_words();
        int t;
        t = 0;
        while (due_q.size() != 0) begin
            if (t > 20) fail_plain("Timed out waiting for words to reach data_o");
            @(negedge fabric_clk_div);
            drive_bit(1'b0);                             // Idle, disabled
            t++;
        end
    endtask

    //**************************************************
    // Compare process
    //**************************************************
    always @(negedge fabric_clk_div) begin
        if (due_q.size() != 0) begin
            if (due_q[0] < edge_cnt) fail_plain("Compare slot for a word was missed");
            if (due_q[0] == edge_cnt) begin
                check_value("data_o", exp_q[0], data_o);
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    //**************************************************
    // Stimulus
    //**************************************************
    initial begin
        logic e;
        reset_buf_n = 1'b0;
        data_i      = 1'b0;
        enable_n    = 1'b1;
        edge_cnt    = 0;
        capture_on  = 1'b0;
        lfsr_state  = 32'h6a46727c;
        apply_reset();
        wait_settle();
        for (int i = 0; i < 60; i++) begin               // Continuous enabled bits
            @(negedge fabric_clk_div);
            drive_bit(1'b1);
        end
        for (int i = 0; i < 90; i++) begin               // Random enable pattern
            @(negedge fabric_clk_div);
            take_bit(e);
            drive_bit(e);
        end
        drain_words();
        while (fed_bits.size() % ww != ww - 1) begin     // Leave a partial word
            @(negedge fabric_clk_div);
            drive_bit(1'b1);
        end
        apply_reset();                                   // Mid-stream reset
        wait_settle();
        for (int i = 0; i < 30; i++) begin
            @(negedge fabric_clk_div);
            drive_bit(1'b1);
        end
        drain_words();
        $display("Test OK");
        $finish;
    end

endmodule

//--- compile.f
rx_serdes_pkg.sv
rx_input_stage.sv
rx_deserializer.sv
rx_word_capture.sv
rx_serdes_top.sv
tb_rx_serdes_top.sv
